//--- phywhisperer_top.f
+incdir+tb
source/pw_pkg.sv
source/pw_reg_bank.sv
source/pw_pattern_matcher.sv
source/pw_trigger_gen.sv
source/pw_capture.sv
source/pw_capture_fifo.sv
source/phywhisperer_top.sv
tb/tb_phywhisperer_top.sv

//--- Bender.yml
package:
  name: phywhisperer_top

sources:
  - source/pw_pkg.sv
  - source/pw_reg_bank.sv
  - source/pw_pattern_matcher.sv
  - source/pw_trigger_gen.sv
  - source/pw_capture.sv
  - source/pw_capture_fifo.sv
  - source/phywhisperer_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_phywhisperer_top.sv

//--- tb/pw_tb_model.svh
function automatic int find_match(int from_e, int to_e);   // edge of the first completing byte
   logic [7:0] win [$];
   bit         hit;
   for (int e = from_e; e <= to_e; e++) begin
      if (fe_log[e].rxvalid) begin
         win.push_back(fe_log[e].data);
         if (win.size() > mcfg.nbytes) begin
            void'(win.pop_front());
         end
         // win[0] is the oldest byte, lines up with pattern byte 0
         hit = (win.size() == mcfg.nbytes);
         for (int k = 0; k < win.size(); k++) begin
            if (((win[k] ^ mcfg.pattern[k]) & mcfg.mask[k]) != 8'h00) begin
               hit = 1'b0;
            end
         end
         if (hit) begin
            return e;
         end
      end
   end
   return -1;
endfunction

// one entry per event after the match edge, first n kept
// returns the edge of the last entry kept
function automatic int build_entries(int m_e, int n);
   logic        err;
   logic        rise;
   logic        fall;
   int          last_e;
   int          t;
   fifo_entry_t ent;
   err    = 1'b0;
   last_e = m_e;
   exp_q.delete();
   for (int e = 2; e <= cyc && exp_q.size() < n; e++) begin
      rise = fe_log[e].rxactive & ~fe_log[e-1].rxactive;
      fall = ~fe_log[e].rxactive & fe_log[e-1].rxactive;
      if (e > m_e && (rise || fe_log[e].rxvalid || fall)) begin
         t = (e - last_e > 255) ? 255 : e - last_e;   // saturating delta
         ent.tdelta = 8'(t);
         if (rise) begin
            ent.cmd  = CMD_RX_START;
            ent.data = 8'h00;
         end else if (fe_log[e].rxvalid) begin
            ent.cmd  = CMD_DATA;
            ent.data = fe_log[e].data;
         end else begin
            ent.cmd  = CMD_RX_END;
            ent.data = {7'b0, err};
         end
         exp_q.push_back(ent);
         last_e = e;
      end
      if (rise) begin
         err = fe_log[e].rxerror;
      end else if (fe_log[e].rxactive) begin
         err = err | fe_log[e].rxerror;
      end
   end
   return last_e;
endfunction

//--- tb/tb_phywhisperer_top.sv
`timescale 1ns/1ps

module tb_phywhisperer_top;
   import pw_pkg::*;

   localparam int LOG_DEPTH = 16384;

   logic        clk;
   logic        rst_n;
   host_req_t   host;
   fe_rx_t      fe;
   logic [7:0]  rdata;
   logic        trig;
   logic        led_cap;
   logic        led_trig;

   integer      seed = 32'hae7f255e;
   int          cyc = 0;               // rising edges so far
   int          arm_e;
   fe_rx_t      fe_log [LOG_DEPTH];    // inputs as sampled on each edge
   logic        trig_log [LOG_DEPTH];  // trig_o after each edge
   logic        led_cap_log [LOG_DEPTH];
   logic        led_trig_log [LOG_DEPTH];
   match_cfg_t  mcfg;
   fifo_entry_t exp_q [$];

   phywhisperer_top DUT (
      .fe_clk      (clk),
      .rst_n_i     (rst_n),
      .host_i      (host),
      .reg_rdata_o (rdata),
      .fe_i        (fe),
      .trig_o      (trig),
      .led_cap_o   (led_cap),
      .led_trig_o  (led_trig)
   );

   `include "pw_tb_model.svh"

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc = cyc + 1;
      fe_log[cyc] = fe;
   end

   always @(negedge clk) begin
      trig_log[cyc]     = trig;        // mid-cycle, away from the edge
      led_cap_log[cyc]  = led_cap;
      led_trig_log[cyc] = led_trig;
      assert (cyc < LOG_DEPTH - 1) else begin
         $display("run took more cycles than the input log holds");
         fail_stop();
      end
   end

   //////////////////////////////
   // helpers

   task automatic fail_stop();
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_val(string name, int got, int exp);
      assert (got == exp) else begin
         $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         fail_stop();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic write_reg(logic [7:0] addr, int bc, logic [7:0] val);
      host = '{addr: addr, bytecnt: 3'(bc), wdata: val, write: 1'b1, read: 1'b0};
      next_cycle();
      host = '0;
   endtask

   task automatic read_reg(logic [7:0] addr, int bc, output logic [7:0] val);
      host = '{addr: addr, bytecnt: 3'(bc), wdata: 8'h00, write: 1'b0, read: 1'b1};
      next_cycle();
      host = '0;
      val = rdata;                     // one cycle after the strobe
   endtask

   task automatic write_and_verify(logic [7:0] addr, int bc, logic [7:0] val);
      logic [7:0] got;
      write_reg(addr, bc, val);
      read_reg(addr, bc, got);
      check_val("reg_rdata_o", got, val);
   endtask

   task automatic send_byte(logic [7:0] b);
      fe = '{data: b, rxvalid: 1'b1, rxactive: 1'b1, rxerror: ($random(seed) & 15) == 0};
      next_cycle();
      if (($random(seed) & 3) == 0) begin   // gap inside the packet
         fe.rxvalid = 1'b0;
         fe.rxerror = 1'b0;
         next_cycle();
      end
   endtask

   // rxactive rises a cycle before the first byte, so edges never tie with bytes
   task automatic send_packet(bit with_pat);
      int         len;
      int         at;
      logic [7:0] b;
      len = 4 + ($random(seed) & 7);
      at  = with_pat ? ($random(seed) & 3) : -1;
      fe  = '{data: 8'h00, rxvalid: 1'b0, rxactive: 1'b1, rxerror: 1'b0};
      next_cycle();
      for (int i = 0; i < len; i++) begin
         if (i == at) begin
            for (int k = 0; k < mcfg.nbytes; k++) begin
               b = $random(seed);
               send_byte((mcfg.pattern[k] & mcfg.mask[k]) | (b & ~mcfg.mask[k]));
            end
         end
         send_byte($random(seed) & 8'h7f);
      end
      fe = '0;
      repeat (1 + ($random(seed) & 3)) next_cycle();
   endtask

   task automatic configure(int nb, int delay, int width, int cap_len);
      for (int k = 0; k < PATTERN_BYTES; k++) begin
         mcfg.pattern[k] = $random(seed);
         mcfg.mask[k]    = (($random(seed) & 3) == 0) ? 8'h00 : 8'($random(seed));
      end
      // newest byte needs bit 7, which random traffic never carries
      mcfg.pattern[nb-1][7] = 1'b1;
      mcfg.mask[nb-1][7]    = 1'b1;
      mcfg.nbytes           = 4'(nb);
      for (int k = 0; k < PATTERN_BYTES; k++) begin
         write_and_verify(REG_PATTERN, k, mcfg.pattern[k]);
         write_and_verify(REG_PATTERN_MASK, k, mcfg.mask[k]);
      end
      write_and_verify(REG_PATTERN_BYTES, 0, 8'(nb));
      for (int b = 0; b < 3; b++) begin
         write_and_verify(REG_TRIG_DELAY, b, 8'(delay >> (8*b)));
         write_and_verify(REG_TRIG_WIDTH, b, 8'(width >> (8*b)));
         if (b < 2) begin
            write_and_verify(REG_CAPTURE_LEN, b, 8'(cap_len >> (8*b)));
         end
      end
   endtask

   task automatic read_entry(fifo_entry_t exp);
      logic [7:0] b;
      read_reg(REG_FIFO, 0, b);
      check_val("fifo data", b, exp.data);
      read_reg(REG_FIFO, 1, b);
      check_val("fifo time", b, exp.tdelta);
      read_reg(REG_FIFO, 2, b);        // pops
      check_val("fifo cmd", b, exp.cmd);
   endtask

   //////////////////////////////
   // one arm, one capture

   task automatic run_case(int nb, int delay, int width, int cap_len, bit drain);
      logic [7:0] st;
      int         m_e;
      int         done_e;
      int         n_keep;
      configure(nb, delay, width, cap_len);
      write_reg(REG_ARM, 0, 8'h01);
      arm_e = cyc;
      next_cycle();
      read_reg(REG_STATUS, 0, st);
      check_val("status after arm", st, 8'h09);
      repeat (3) send_packet(1'b0);
      send_packet(1'b1);
      repeat (300) next_cycle();       // saturates the next delta
      read_reg(REG_STATUS, 0, st);
      for (int lim = 0; !st[2]; lim++) begin
         assert (lim < 50) else begin
            $display("capture did not finish after %0d extra packets", lim);
            fail_stop();
         end
         send_packet(1'b0);
         read_reg(REG_STATUS, 0, st);
      end
      m_e = find_match(arm_e + 2, cyc);
      assert (m_e > 0) else begin
         $display("no pattern match found in the driven bytes");
         fail_stop();
      end
      for (int lim = 0; cyc <= m_e + delay + width + 2; lim++) begin
         assert (lim < 200) else begin
            $display("timed out waiting for the trigger window to pass");
            fail_stop();
         end
         next_cycle();
      end
      send_packet(1'b1);               // no re-arm, so ignored
      done_e = build_entries(m_e, cap_len);
      check_val("entries before done", exp_q.size(), cap_len);
      // armed until the edge after the last entry, capturing from the match
      for (int e = arm_e; e < cyc; e++) begin
         check_val($sformatf("trig_o at edge %0d", e), trig_log[e],
                   (e > m_e + delay) && (e <= m_e + delay + width));
         check_val($sformatf("led_cap_o at edge %0d", e), led_cap_log[e],
                   e <= done_e);
         check_val($sformatf("led_trig_o at edge %0d", e), led_trig_log[e],
                   (e > m_e) && (e <= done_e));
      end
      read_reg(REG_STATUS, 0, st);
      check_val("status at done", st, (cap_len > FIFO_DEPTH) ? 8'h14 : 8'h04);
      check_val("led_cap_o", led_cap, 0);
      check_val("led_trig_o", led_trig, 0);
      n_keep = drain ? ((cap_len > FIFO_DEPTH) ? FIFO_DEPTH : cap_len) : 1;
      for (int i = 0; i < n_keep; i++) begin
         read_entry(exp_q[i]);
      end
      if (drain) begin
         read_reg(REG_FIFO, 2, st);
         check_val("fifo empty flag", st, 8'h80);
      end
   endtask

   initial begin
      logic [7:0] st;
      rst_n = 1'b0;
      host  = '0;
      fe    = '0;
      repeat (8) next_cycle();
      rst_n = 1'b1;
      check_val("trig_o", trig, 0);
      check_val("led_cap_o", led_cap, 0);
      check_val("led_trig_o", led_trig, 0);
      read_reg(REG_STATUS, 0, st);
      check_val("status after reset", st, 8'h08);
      for (int a = REG_PATTERN; a <= REG_CAPTURE_LEN; a++) begin
         read_reg(8'(a), 0, st);
         check_val($sformatf("register 0x%0h after reset", a), st, 0);
      end
      run_case(8, 0, 4, 12, 1'b1);
      run_case(3, 17, 1, 20, 1'b0);     // leftovers flushed by next arm
      run_case(5, $random(seed) & 31, 7, 80, 1'b1);
      run_case(2, 3, 0, 6, 1'b1);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- source/phywhisperer_top.sv
`timescale 1ns/1ps

module phywhisperer_top (
   input  logic              fe_clk,
   input  logic              rst_n_i,
   input  pw_pkg::host_req_t host_i,
   output logic [7:0]        reg_rdata_o,
   input  pw_pkg::fe_rx_t    fe_i,
   output logic              trig_o,
   output logic              led_cap_o,
   output logic              led_trig_o
);
   import pw_pkg::*;

   match_cfg_t                   match_cfg;
   trig_cfg_t                    trig_cfg;
   logic [CAPTURE_LEN_WIDTH-1:0] capture_len;
   logic                         armed;
   logic                         arm_start;      // also flushes the FIFO
   logic                         capturing;
   logic                         capture_done;
   logic                         match;
   fifo_entry_t                  entry;
   logic                         push;
   fifo_entry_t                  head;
   logic                         pop;
   logic                         fifo_empty;
   logic                         overflow;

   assign led_cap_o  = armed;
   assign led_trig_o = capturing;

   //////////////////////////////
   // host side

   pw_reg_bank U_reg_bank (
      .fe_clk          (fe_clk),
      .rst_n_i         (rst_n_i),
      .host_i          (host_i),
      .reg_rdata_o     (reg_rdata_o),
      .match_cfg_o     (match_cfg),
      .trig_cfg_o      (trig_cfg),
      .capture_len_o   (capture_len),
      .armed_o         (armed),
      .arm_start_o     (arm_start),
      .capturing_i     (capturing),
      .capture_done_i  (capture_done),
      .fifo_head_i     (head),
      .fifo_empty_i    (fifo_empty),
      .overflow_i      (overflow),
      .fifo_pop_o      (pop)
   );

   //////////////////////////////
   // match, trigger, capture

   pw_pattern_matcher U_pattern_matcher (
      .fe_clk          (fe_clk),
      .rst_n_i         (rst_n_i),
      .fe_i            (fe_i),
      .match_cfg_i     (match_cfg),
      .armed_i         (armed),
      .arm_start_i     (arm_start),
      .capturing_i     (capturing),
      .match_o         (match)
   );

   pw_trigger_gen U_trigger (
      .fe_clk          (fe_clk),
      .rst_n_i         (rst_n_i),
      .trig_cfg_i      (trig_cfg),
      .match_i         (match),
      .armed_i         (armed),
      .trig_o          (trig_o)
   );

   pw_capture U_capture (
      .fe_clk          (fe_clk),
      .rst_n_i         (rst_n_i),
      .fe_i            (fe_i),
      .match_i         (match),
      .arm_start_i     (arm_start),
      .capture_len_i   (capture_len),
      .capturing_o     (capturing),
      .capture_done_o  (capture_done),
      .entry_o         (entry),
      .push_o          (push)
   );

   pw_capture_fifo U_fifo (
      .fe_clk          (fe_clk),
      .rst_n_i         (rst_n_i),
      .flush_i         (arm_start),
      .entry_i         (entry),
      .push_i          (push),
      .pop_i           (pop),
      .head_o          (head),
      .empty_o         (fifo_empty),
      .overflow_o      (overflow)
   );

endmodule

//--- source/pw_capture_fifo.sv
`timescale 1ns/1ps

module pw_capture_fifo (
   input  logic                fe_clk,
   input  logic                rst_n_i,
   input  logic                flush_i,
   input  pw_pkg::fifo_entry_t entry_i,
   input  logic                push_i,
   input  logic                pop_i,
   output pw_pkg::fifo_entry_t head_o,
   output logic                empty_o,
   output logic                overflow_o
);
   import pw_pkg::*;

   fifo_entry_t        mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wptr_q;
   logic [FIFO_AW-1:0] rptr_q;
   logic [FIFO_AW:0]   count_q;
   logic               full;
   logic               do_push;
   logic               do_pop;

   assign full    = (count_q == FIFO_DEPTH);
   assign empty_o = (count_q == '0);
   assign do_push = push_i & ~full & ~flush_i;    // dropped when full
   assign do_pop  = pop_i & ~empty_o & ~flush_i;
   assign head_o  = mem[rptr_q];

   always_ff @(posedge fe_clk) begin
      if (do_push) begin
         mem[wptr_q] <= entry_i;
      end
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wptr_q     <= '0;
         rptr_q     <= '0;
         count_q    <= '0;
         overflow_o <= 1'b0;
      end else if (flush_i) begin
         wptr_q     <= '0;
         rptr_q     <= '0;
         count_q    <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (do_push) begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (do_pop) begin
            rptr_q <= rptr_q + 1'b1;
         end
         count_q <= count_q + (FIFO_AW+1)'(do_push) - (FIFO_AW+1)'(do_pop);
         if (push_i && full) begin
            overflow_o <= 1'b1;             // sticky until flush
         end
      end
   end

endmodule

//--- source/pw_capture.sv
`timescale 1ns/1ps

module pw_capture (
   input  logic                                 fe_clk,
   input  logic                                 rst_n_i,
   input  pw_pkg::fe_rx_t                       fe_i,
   input  logic                                 match_i,
   input  logic                                 arm_start_i,
   input  logic [pw_pkg::CAPTURE_LEN_WIDTH-1:0] capture_len_i,
   output logic                                 capturing_o,
   output logic                                 capture_done_o,
   output pw_pkg::fifo_entry_t                  entry_o,
   output logic                                 push_o
);
   import pw_pkg::*;

   logic                         active_q;   // rxactive one cycle back
   logic                         err_q;      // rxerror seen in packet
   logic [TIME_WIDTH-1:0]        tcnt_q;
   logic [TIME_WIDTH-1:0]        delta;
   logic [CAPTURE_LEN_WIDTH-1:0] count_q;
   logic                         rise;
   logic                         fall;
   logic                         record;
   logic                         last;
   fifo_entry_t                  entry_d;

   assign rise  = fe_i.rxactive & ~active_q;
   assign fall  = ~fe_i.rxactive & active_q;
   assign delta = match_i ? TIME_WIDTH'(1) : tcnt_q;   // first entry counts from match
   assign last  = (count_q + 1'b1) >= capture_len_i;

   // at most one entry per cycle
   assign record = (capturing_o | match_i) & ~capture_done_o & ~arm_start_i &
                   (rise | fe_i.rxvalid | fall);

   always_comb begin
      entry_d.tdelta = delta;
      if (rise) begin
         entry_d.cmd  = CMD_RX_START;
         entry_d.data = 8'h00;
      end else if (fe_i.rxvalid) begin
         entry_d.cmd  = CMD_DATA;
         entry_d.data = fe_i.data;
      end else begin
         entry_d.cmd  = CMD_RX_END;
         entry_d.data = {7'b0, err_q};
      end
   end

   always_ff @(posedge fe_clk) begin
      if (record) begin
         entry_o <= entry_d;
      end
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         active_q       <= 1'b0;
         err_q          <= 1'b0;
         tcnt_q         <= '0;
         count_q        <= '0;
         capturing_o    <= 1'b0;
         capture_done_o <= 1'b0;
         push_o         <= 1'b0;
      end else begin
         active_q       <= fe_i.rxactive;
         push_o         <= record;
         capture_done_o <= record & last;

         if (rise) begin
            err_q <= fe_i.rxerror;
         end else if (fe_i.rxactive) begin
            err_q <= err_q | fe_i.rxerror;
         end

         // saturating delta timer
         if (record) begin
            tcnt_q <= TIME_WIDTH'(1);
         end else begin
            tcnt_q <= (delta == '1) ? delta : delta + 1'b1;
         end

         if (arm_start_i) begin
            count_q     <= '0;
            capturing_o <= 1'b0;
         end else begin
            if (record) begin
               count_q <= count_q + 1'b1;
            end
            if (capture_done_o) begin
               capturing_o <= 1'b0;         // drops as the last entry lands
            end else if (match_i) begin
               capturing_o <= 1'b1;
            end
         end
      end
   end

endmodule

//--- source/pw_trigger_gen.sv
`timescale 1ns/1ps

module pw_trigger_gen (
   input  logic              fe_clk,
   input  logic              rst_n_i,
   input  pw_pkg::trig_cfg_t trig_cfg_i,
   input  logic              match_i,
   input  logic              armed_i,
   output logic              trig_o
);
   import pw_pkg::*;

   trig_state_e                 state_q;
   logic [TRIG_DELAY_WIDTH-1:0] cnt_q;     // delay, then width
   logic [TRIG_DELAY_WIDTH-1:0] width_m1;
   logic                        fire;

   assign width_m1 = TRIG_DELAY_WIDTH'(trig_cfg_i.width) - 1'b1;

   // delay of 0 goes straight from the match to the pulse
   assign fire = ((state_q == TRIG_IDLE) && match_i && (trig_cfg_i.delay == '0)) ||
                 ((state_q == TRIG_DELAY) && (cnt_q == '0));

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= TRIG_IDLE;
         cnt_q   <= '0;
         trig_o  <= 1'b0;
      end else if (fire) begin
         if (trig_cfg_i.width == '0) begin
            state_q <= TRIG_DONE;           // zero width, no pulse
         end else begin
            state_q <= TRIG_PULSE;
            cnt_q   <= width_m1;
            trig_o  <= 1'b1;
         end
      end else begin
         case (state_q)
            TRIG_IDLE: begin
               if (match_i) begin
                  state_q <= TRIG_DELAY;
                  cnt_q   <= trig_cfg_i.delay - 1'b1;
               end
            end
            TRIG_DELAY: cnt_q <= cnt_q - 1'b1;
            TRIG_PULSE: begin
               if (cnt_q == '0) begin
                  state_q <= TRIG_DONE;
                  trig_o  <= 1'b0;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            default: begin
               // one pulse per arm
               if (!armed_i) begin
                  state_q <= TRIG_IDLE;
               end
            end
         endcase
      end
   end

endmodule

//--- source/pw_pattern_matcher.sv
`timescale 1ns/1ps

module pw_pattern_matcher (
   input  logic               fe_clk,
   input  logic               rst_n_i,
   input  pw_pkg::fe_rx_t     fe_i,
   input  pw_pkg::match_cfg_t match_cfg_i,
   input  logic               armed_i,
   input  logic               arm_start_i,
   input  logic               capturing_i,
   output logic               match_o
);
   import pw_pkg::*;

   logic [PATTERN_BYTES-1:0][7:0] hist_q;  // [0] is newest
   logic [PATTERN_BYTES-1:0][7:0] cand;    // history plus incoming byte
   logic [3:0]                    fill_q;  // bytes seen since arm, saturating
   logic [3:0]                    nb;
   logic                          enough;
   logic                          equal;

   assign nb     = (match_cfg_i.nbytes > PATTERN_BYTES) ? 4'(PATTERN_BYTES)
                                                        : match_cfg_i.nbytes;
   assign cand   = {hist_q[PATTERN_BYTES-2:0], fe_i.data};
   assign enough = (fill_q + 1'b1) >= nb;

   // pattern byte k lines up with the byte nb-1-k places back
   always_comb begin
      equal = 1'b1;
      for (int k = 0; k < PATTERN_BYTES; k++) begin
         if (k < nb) begin
            if (((cand[nb-1-k] ^ match_cfg_i.pattern[k]) & match_cfg_i.mask[k]) != 8'h00) begin
               equal = 1'b0;
            end
         end
      end
   end

   always_ff @(posedge fe_clk) begin
      if (fe_i.rxvalid) begin
         hist_q <= cand;
      end
   end

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fill_q  <= '0;
         match_o <= 1'b0;
      end else begin
         if (arm_start_i) begin
            fill_q <= '0;
         end else if (fe_i.rxvalid && (fill_q != PATTERN_BYTES)) begin
            fill_q <= fill_q + 1'b1;
         end
         // no back-to-back pulses
         match_o <= fe_i.rxvalid & armed_i & ~arm_start_i & ~capturing_i &
                    ~match_o & enough & equal;
      end
   end

endmodule

//--- source/pw_reg_bank.sv
`timescale 1ns/1ps

module pw_reg_bank (
   input  logic                                 fe_clk,
   input  logic                                 rst_n_i,
   input  pw_pkg::host_req_t                    host_i,
   output logic [7:0]                           reg_rdata_o,
   output pw_pkg::match_cfg_t                   match_cfg_o,
   output pw_pkg::trig_cfg_t                    trig_cfg_o,
   output logic [pw_pkg::CAPTURE_LEN_WIDTH-1:0] capture_len_o,
   output logic                                 armed_o,
   output logic                                 arm_start_o,
   input  logic                                 capturing_i,
   input  logic                                 capture_done_i,
   input  pw_pkg::fifo_entry_t                  fifo_head_i,
   input  logic                                 fifo_empty_i,
   input  logic                                 overflow_i,
   output logic                                 fifo_pop_o
);
   import pw_pkg::*;

   logic        done_q;      // sticky, until next arm
   logic [31:0] wide_cur;
   logic [31:0] wide_wr;
   logic [7:0]  wide_byte;
   logic [7:0]  fifo_byte;
   logic [7:0]  rd_mux;

   // delay, width and length share one little-endian byte path
   always_comb begin
      case (host_i.addr)
         REG_TRIG_DELAY:  wide_cur = 32'(trig_cfg_o.delay);
         REG_TRIG_WIDTH:  wide_cur = 32'(trig_cfg_o.width);
         REG_CAPTURE_LEN: wide_cur = 32'(capture_len_o);
         default:         wide_cur = '0;
      endcase
      wide_wr = wide_cur;
      if (!host_i.bytecnt[2]) begin
         wide_wr[8*host_i.bytecnt[1:0] +: 8] = host_i.wdata;
      end
   end

   assign wide_byte = host_i.bytecnt[2] ? 8'h00 : wide_cur[8*host_i.bytecnt[1:0] +: 8];

   always_comb begin
      case (host_i.bytecnt)
         3'd0:    fifo_byte = fifo_head_i.data;
         3'd1:    fifo_byte = 8'(fifo_head_i.tdelta);
         3'd2:    fifo_byte = fifo_empty_i ? 8'h80 : {6'b0, fifo_head_i.cmd};
         default: fifo_byte = 8'h00;
      endcase
   end

   always_comb begin
      case (host_i.addr)
         REG_ARM:           rd_mux = {7'b0, armed_o};
         REG_STATUS:        rd_mux = {3'b0, overflow_i, fifo_empty_i, done_q,
                                      capturing_i, armed_o};
         REG_PATTERN:       rd_mux = match_cfg_o.pattern[host_i.bytecnt];
         REG_PATTERN_MASK:  rd_mux = match_cfg_o.mask[host_i.bytecnt];
         REG_PATTERN_BYTES: rd_mux = {4'b0, match_cfg_o.nbytes};
         REG_FIFO:          rd_mux = fifo_byte;
         default:           rd_mux = wide_byte;
      endcase
   end

   // last byte of an entry advances the head
   assign fifo_pop_o = host_i.read && (host_i.addr == REG_FIFO) &&
                       (host_i.bytecnt == 3'd2) && !fifo_empty_i;

   always_ff @(posedge fe_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         match_cfg_o   <= '0;
         trig_cfg_o    <= '0;
         capture_len_o <= '0;
         armed_o       <= 1'b0;
         arm_start_o   <= 1'b0;
         done_q        <= 1'b0;
         reg_rdata_o   <= 8'h00;
      end else begin
         arm_start_o <= 1'b0;
         if (capture_done_i) begin
            armed_o <= 1'b0;                // arm clears itself
            done_q  <= 1'b1;
         end else if (arm_start_o) begin
            done_q  <= 1'b0;
         end

         if (host_i.write) begin
            case (host_i.addr)
               REG_ARM: begin
                  armed_o     <= host_i.wdata[0];
                  arm_start_o <= host_i.wdata[0];
               end
               REG_PATTERN:       match_cfg_o.pattern[host_i.bytecnt] <= host_i.wdata;
               REG_PATTERN_MASK:  match_cfg_o.mask[host_i.bytecnt] <= host_i.wdata;
               REG_PATTERN_BYTES: match_cfg_o.nbytes <= host_i.wdata[3:0];
               REG_TRIG_DELAY:    trig_cfg_o.delay <= wide_wr[TRIG_DELAY_WIDTH-1:0];
               REG_TRIG_WIDTH:    trig_cfg_o.width <= wide_wr[TRIG_WIDTH_WIDTH-1:0];
               REG_CAPTURE_LEN:   capture_len_o <= wide_wr[CAPTURE_LEN_WIDTH-1:0];
               default: ;
            endcase
         end

         if (host_i.read) begin
            reg_rdata_o <= rd_mux;          // held until next read
         end
      end
   end

endmodule

//--- source/pw_pkg.sv
package pw_pkg;

   //////////////////////////////
   // sizes

   localparam int PATTERN_BYTES     = 8;
   localparam int BYTECNT_WIDTH     = 3;
   localparam int TRIG_DELAY_WIDTH  = 20;
   localparam int TRIG_WIDTH_WIDTH  = 17;
   localparam int CAPTURE_LEN_WIDTH = 16;
   localparam int TIME_WIDTH        = 8;
   localparam int FIFO_DEPTH        = 64;
   localparam int FIFO_AW           = $clog2(FIFO_DEPTH);

   //////////////////////////////
   // encodings

   typedef enum logic [7:0] {
      REG_ARM           = 8'h00,
      REG_STATUS        = 8'h01,
      REG_PATTERN       = 8'h02,
      REG_PATTERN_MASK  = 8'h03,
      REG_PATTERN_BYTES = 8'h04,
      REG_TRIG_DELAY    = 8'h05,
      REG_TRIG_WIDTH    = 8'h06,
      REG_CAPTURE_LEN   = 8'h07,
      REG_FIFO          = 8'h08
   } reg_addr_e;

   typedef enum logic [1:0] {
      CMD_DATA     = 2'd0,
      CMD_RX_START = 2'd1,
      CMD_RX_END   = 2'd2
   } cap_cmd_e;

   typedef enum logic [1:0] {
      TRIG_IDLE,
      TRIG_DELAY,
      TRIG_PULSE,
      TRIG_DONE
   } trig_state_e;

   //////////////////////////////
   // bundles

   typedef struct packed {
      logic [7:0]               addr;      // a reg_addr_e value
      logic [BYTECNT_WIDTH-1:0] bytecnt;
      logic [7:0]               wdata;
      logic                     write;
      logic                     read;
   } host_req_t;

   typedef struct packed {
      logic [7:0] data;
      logic       rxvalid;
      logic       rxactive;
      logic       rxerror;
   } fe_rx_t;

   typedef struct packed {
      logic [PATTERN_BYTES-1:0][7:0] pattern;
      logic [PATTERN_BYTES-1:0][7:0] mask;
      logic [3:0]                    nbytes;
   } match_cfg_t;

   typedef struct packed {
      logic [TRIG_DELAY_WIDTH-1:0] delay;
      logic [TRIG_WIDTH_WIDTH-1:0] width;
   } trig_cfg_t;

   typedef struct packed {
      cap_cmd_e              cmd;
      logic [TIME_WIDTH-1:0] tdelta;       // cycles since previous entry
      logic [7:0]            data;
   } fifo_entry_t;

endpackage
